// ==== rx_control_top.f ====
src/rx_radio_pkg.sv
src/rx_ctrl_pkg.sv
src/rx_cmd_if.sv
src/rx_short_fifo.sv
src/rx_cmd_settings.sv
src/rx_time_compare.sv
src/rx_ctrl_core.sv
src/rx_control_top.sv
sim/rx_control_tb.sv

// ==== Bender.yml ====
package:
  name: rx_control

sources:
  - src/rx_radio_pkg.sv
  - src/rx_ctrl_pkg.sv
  - src/rx_cmd_if.sv
  - src/rx_short_fifo.sv
  - src/rx_cmd_settings.sv
  - src/rx_time_compare.sv
  - src/rx_ctrl_core.sv
  - src/rx_control_top.sv
  - target: test
    files:
      - sim/rx_control_tb.sv

// ==== sim/rx_control_tb.sv ====
module rx_control_tb;
  import rx_radio_pkg::*;
  import rx_ctrl_pkg::*;

  localparam sid_t DATA_SID      = 32'h0000_0a10;
  localparam sid_t RESP_SID      = 32'h0000_0a11;
  localparam int   TOTAL_SAMPLES = 81;   // Strobed samples over all tests
  localparam int   TOTAL_CMDS    = 13;
  // Margin of four for random strobe gaps and drain stalls
  localparam int   WATCHDOG_CYCLES = 4 * (TOTAL_SAMPLES + 20 * TOTAL_CMDS);

  logic        clk;
  logic        i_rst_n;
  logic        i_clear;
  vita_time_t  vita_now;     // Radio time seen by the DUT at the next rising edge
  logic        i_set_stb;
  set_addr_t   i_set_addr;
  logic [31:0] i_set_data;
  sample_t     i_sample;
  logic        i_strobe;
  logic        o_run;
  logic [31:0] o_rx_tdata;
  logic        o_rx_tlast;
  rx_header_t  o_rx_tuser;
  logic        o_rx_tvalid;
  logic        i_rx_tready;
  rx_beat_t    out_beat;

  logic [31:0] rng;
  int          ready_mode;   // 0 held low, 1 held high, 2 random
  seqnum_t     model_seq;
  sample_t     sent[$];      // Samples of the burst in progress
  vita_time_t  sent_time[$];
  rx_beat_t    exp_q[$];
  rx_beat_t    got[$];

  rx_control_top i_dut (
    .clk         (clk),
    .i_rst_n     (i_rst_n),
    .i_clear     (i_clear),
    .i_vita_time (vita_now),
    .i_sid       (DATA_SID),
    .i_resp_sid  (RESP_SID),
    .i_set_stb   (i_set_stb),
    .i_set_addr  (i_set_addr),
    .i_set_data  (i_set_data),
    .i_sample    (i_sample),
    .i_strobe    (i_strobe),
    .o_run       (o_run),
    .o_rx_tdata  (o_rx_tdata),
    .o_rx_tlast  (o_rx_tlast),
    .o_rx_tuser  (o_rx_tuser),
    .o_rx_tvalid (o_rx_tvalid),
    .i_rx_tready (i_rx_tready)
  );

  always #50 clk = ~clk;

  assign out_beat = {o_rx_tdata, o_rx_tlast, o_rx_tuser};

  // Every accepted output beat
  always @(posedge clk) begin
    if (i_rst_n && o_rx_tvalid && i_rx_tready) got.push_back(out_beat);
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("Testbench failed");
    $fatal(1, "Stopped at the first failure");
  endtask

  task automatic check_beat(input string name, input rx_beat_t exp, input rx_beat_t act);
    logic ok;
    ok = (act.data === exp.data) && (act.last === exp.last) &&
         (act.header.is_error === exp.header.is_error) &&
         (act.header.eob === exp.header.eob) &&
         (act.header.seqnum === exp.header.seqnum) &&
         (act.header.sid === exp.header.sid);
    if (exp.header.is_error) begin
      // Error stamp only known to lie between the cause and the arrival
      ok = ok && (act.header.timestamp >= exp.header.timestamp) &&
           (act.header.timestamp <= vita_now);
    end else begin
      ok = ok && (act.header.timestamp === exp.header.timestamp);
    end
    if (ok !== 1'b1) begin
      report_failure($sformatf("** Error %s: expected %h, actual %h", name, exp, act));
    end
  endtask

  task automatic check_run(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      report_failure($sformatf("** Error %s: o_run expected %b, actual %b", name, exp, act));
    end
  endtask

  // All stimulus changes on the falling edge
  task automatic next_cycle();
    @(negedge clk);
    vita_now  = vita_now + 1;
    i_set_stb = 1'b0;
    i_strobe  = 1'b0;
    case (ready_mode)
      0: i_rx_tready = 1'b0;
      1: i_rx_tready = 1'b1;
      default: begin
        rng         = xorshift32(rng);
        i_rx_tready = rng[0];
      end
    endcase
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) next_cycle();
  endtask

  task automatic write_setting(input set_addr_t addr, input logic [31:0] data);
    next_cycle();
    i_set_stb  = 1'b1;
    i_set_addr = addr;
    i_set_data = data;
  endtask

  task automatic write_cmd(input logic imm, input logic chain, input logic reload,
                           input logic [27:0] lines, input vita_time_t t);
    write_setting(SR_COMMAND, {imm, chain, reload, 1'b0, lines});
    write_setting(SR_TIME_HI, t[63:32]);
    write_setting(SR_TIME_LO, t[31:0]);   // Pushes the command
  endtask

  task automatic strobe_samples(input int n, input logic dense);
    int done;
    done = 0;
    while (done < n) begin
      next_cycle();
      rng = xorshift32(rng);
      if (dense || rng[31]) begin
        rng      = xorshift32(rng);
        i_strobe = 1'b1;
        i_sample = rng;
        sent.push_back(rng);
        sent_time.push_back(vita_now);
        done++;
      end
    end
  endtask

  // Splits the logged burst into packets of m beats, eob on the final beat
  task automatic build_burst(input int m);
    rx_beat_t   b;
    vita_time_t pkt_time;
    int         pos;
    int         i;
    for (i = 0; i < sent.size(); i++) begin
      pos = i % m;
      if (pos == 0) pkt_time = sent_time[i];
      b.data             = sent[i];
      b.last             = (pos == m - 1) || (i == sent.size() - 1);
      b.header.is_error  = 1'b0;
      b.header.eob       = (i == sent.size() - 1);
      b.header.seqnum    = model_seq;
      b.header.sid       = DATA_SID;
      b.header.timestamp = pkt_time;
      exp_q.push_back(b);
      if (b.last) model_seq = model_seq + 1'b1;
    end
    sent.delete();
    sent_time.delete();
  endtask

  task automatic add_error(input rx_err_t code, input vita_time_t t_min);
    rx_beat_t b;
    b.data             = code;
    b.last             = 1'b0;
    b.header.is_error  = 1'b1;
    b.header.eob       = 1'b1;
    b.header.seqnum    = model_seq;
    b.header.sid       = RESP_SID;
    b.header.timestamp = t_min;       // Lower bound only
    exp_q.push_back(b);
    b.data = '0;
    b.last = 1'b1;
    exp_q.push_back(b);
    model_seq = model_seq + 1'b1;
  endtask

  task automatic compare_beats(input string name);
    rx_beat_t exp;
    rx_beat_t act;
    while (got.size() < exp_q.size()) next_cycle();
    while (exp_q.size() > 0) begin
      exp = exp_q.pop_front();
      act = got.pop_front();
      check_beat(name, exp, act);
    end
    idle_cycles(3);
    if (got.size() != 0) begin
      report_failure($sformatf("%s: %0d beats arrived beyond the expected ones",
                               name, got.size()));
    end
  endtask

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    report_failure($sformatf("Timeout: tests did not finish within %0d cycles",
                             WATCHDOG_CYCLES));
  end

  initial begin
    vita_time_t t0;
    vita_time_t exec;
    vita_time_t err_time;
    int         kept;
    int         k;
    clk         = 1'b0;
    i_rst_n     = 1'b0;
    i_clear     = 1'b0;
    vita_now    = '0;
    i_set_stb   = 1'b0;
    i_set_addr  = '0;
    i_set_data  = '0;
    i_sample    = '0;
    i_strobe    = 1'b0;
    i_rx_tready = 1'b0;
    rng         = 32'd1;
    ready_mode  = 1;
    model_seq   = '0;

    idle_cycles(2);    // Reset seen on two rising edges
    i_rst_n = 1'b1;
    next_cycle();
    check_run("reset", 1'b0, o_run);
    if (o_rx_tvalid !== 1'b0) report_failure("Output stream valid right after reset");

    // Immediate commands, packets of maxlen beats
    write_setting(SR_MAXLEN, 32'd6);
    write_cmd(1'b1, 1'b0, 1'b0, 28'd20, '0);
    idle_cycles(4);
    check_run("immediate 20/6", 1'b1, o_run);
    strobe_samples(20, 1'b0);
    ready_mode = 2;
    build_burst(6);
    compare_beats("immediate 20/6");
    check_run("immediate 20/6", 1'b0, o_run);

    ready_mode = 1;
    write_setting(SR_MAXLEN, 32'd3);
    write_cmd(1'b1, 1'b0, 1'b0, 28'd8, '0);
    idle_cycles(4);
    strobe_samples(8, 1'b0);
    ready_mode = 2;
    build_burst(3);
    compare_beats("immediate 8/3");
    check_run("immediate 8/3", 1'b0, o_run);

    // Timed command must not start before its time
    ready_mode = 1;
    write_setting(SR_MAXLEN, 32'd4);
    exec = vita_now + 40;
    write_cmd(1'b0, 1'b0, 1'b0, 28'd10, exec);
    while (vita_now <= exec) begin
      next_cycle();
      check_run("timed early", 1'b0, o_run);
    end
    idle_cycles(4);
    check_run("timed", 1'b1, o_run);
    strobe_samples(10, 1'b0);
    ready_mode = 2;
    build_burst(4);
    compare_beats("timed");
    check_run("timed", 1'b0, o_run);

    err_time = vita_now;
    write_cmd(1'b0, 1'b0, 1'b0, 28'd8, vita_now - 5);   // Already in the past
    add_error(ERR_LATECMD, err_time);
    compare_beats("late command");
    check_run("late command", 1'b0, o_run);

    // Chain into a queued follower gives one burst
    ready_mode = 1;
    write_setting(SR_MAXLEN, 32'd5);
    write_cmd(1'b1, 1'b1, 1'b0, 28'd7, '0);
    write_cmd(1'b1, 1'b0, 1'b0, 28'd5, '0);
    idle_cycles(4);
    check_run("chain", 1'b1, o_run);
    strobe_samples(12, 1'b0);
    ready_mode = 2;
    build_burst(5);
    compare_beats("chain");
    check_run("chain", 1'b0, o_run);

    // Reload repeats until the halt ends the third round
    ready_mode = 1;
    write_setting(SR_MAXLEN, 32'd4);
    write_cmd(1'b1, 1'b1, 1'b1, 28'd6, '0);
    idle_cycles(4);
    strobe_samples(14, 1'b0);
    write_setting(SR_HALT, 32'd0);
    strobe_samples(4, 1'b0);
    ready_mode = 2;
    build_burst(4);
    compare_beats("reload halt");
    check_run("reload halt", 1'b0, o_run);

    ready_mode = 1;
    write_setting(SR_MAXLEN, 32'd8);
    write_cmd(1'b1, 1'b1, 1'b0, 28'd5, '0);
    idle_cycles(4);
    strobe_samples(5, 1'b0);
    err_time   = sent_time[$];
    ready_mode = 2;
    build_burst(8);
    add_error(ERR_BROKENCHAIN, err_time);
    compare_beats("broken chain");
    check_run("broken chain", 1'b0, o_run);

    // Overrun under back-pressure
    ready_mode = 1;
    write_setting(SR_MAXLEN, 32'd64);
    write_cmd(1'b1, 1'b0, 1'b0, 28'd100, '0);
    idle_cycles(4);
    check_run("overrun", 1'b1, o_run);
    ready_mode = 0;
    strobe_samples(8, 1'b1);
    idle_cycles(3);
    ready_mode = 1;
    while (!(got.size() >= 2 && got[$].header.is_error && got[$].last)) next_cycle();
    kept = got.size() - 2;
    if (kept < 1 || kept > sent.size()) begin
      report_failure($sformatf("overrun: %0d data beats for %0d samples sent",
                               kept, sent.size()));
    end
    err_time = sent_time[0];
    while (sent.size() > kept) begin
      void'(sent.pop_back());
      void'(sent_time.pop_back());
    end
    build_burst(64);
    add_error(ERR_OVERRUN, err_time);
    compare_beats("overrun");
    check_run("overrun", 1'b0, o_run);

    // Flushed timed commands never run
    t0 = vita_now;
    for (k = 0; k < 4; k++) begin
      write_cmd(1'b0, 1'b0, 1'b0, 28'd4, t0 + 40 + 10 * k);
    end
    write_setting(SR_CLEAR_CMDS, 32'd0);
    while (vita_now < t0 + 110) begin
      next_cycle();
      rng      = xorshift32(rng);
      i_strobe = rng[0];
      i_sample = rng;
      check_run("clear", 1'b0, o_run);
    end

    idle_cycles(3);
    if (got.size() != 0) begin
      report_failure($sformatf("%0d beats arrived after the command queue was cleared",
                               got.size()));
    end else begin
      $display("Testbench passed");
      $finish;
    end
  end

endmodule

// ==== src/rx_control_top.sv ====
module rx_control_top (
  input  logic                     clk,
  input  logic                     i_rst_n,
  input  logic                     i_clear,
  input  rx_radio_pkg::vita_time_t i_vita_time,
  input  rx_radio_pkg::sid_t       i_sid,
  input  rx_radio_pkg::sid_t       i_resp_sid,
  input  logic                     i_set_stb,
  input  rx_ctrl_pkg::set_addr_t   i_set_addr,
  input  logic [31:0]              i_set_data,
  input  rx_radio_pkg::sample_t    i_sample,
  input  logic                     i_strobe,
  output logic                     o_run,
  output logic [31:0]              o_rx_tdata,
  output logic                     o_rx_tlast,
  output rx_radio_pkg::rx_header_t o_rx_tuser,
  output logic                     o_rx_tvalid,
  input  logic                     i_rx_tready
);
  import rx_radio_pkg::*;
  import rx_ctrl_pkg::*;

  rx_beat_t core_beat;
  rx_beat_t out_beat;
  logic     core_valid;
  logic     core_ready;
  logic     now;
  logic     late;

  rx_cmd_if cmd_if ();

  rx_cmd_settings u_settings (
    .clk        (clk),
    .i_rst_n    (i_rst_n),
    .i_clear    (i_clear),
    .i_set_stb  (i_set_stb),
    .i_set_addr (i_set_addr),
    .i_set_data (i_set_data),
    .cmd_if     (cmd_if.settings)
  );

  // Compares against whatever command sits at the queue head
  rx_time_compare u_time_compare (
    .clk            (clk),
    .i_rst_n        (i_rst_n),
    .i_time_now     (i_vita_time),
    .i_trigger_time (cmd_if.cmd.exec_time),
    .o_now          (now),
    .o_late         (late)
  );

  rx_ctrl_core u_core (
    .clk          (clk),
    .i_rst_n      (i_rst_n),
    .i_clear      (i_clear),
    .i_vita_time  (i_vita_time),
    .i_sid        (i_sid),
    .i_resp_sid   (i_resp_sid),
    .i_sample     (i_sample),
    .i_strobe     (i_strobe),
    .i_now        (now),
    .i_late       (late),
    .cmd_if       (cmd_if.core),
    .o_beat       (core_beat),
    .o_beat_valid (core_valid),
    .i_beat_ready (core_ready),
    .o_run        (o_run)
  );

  // Output queue soaks up short downstream stalls
  rx_short_fifo #(
    .T     (rx_beat_t),
    .DEPTH (OUT_FIFO_DEPTH)
  ) u_out_fifo (
    .clk     (clk),
    .i_rst_n (i_rst_n),
    .i_clear (i_clear),
    .i_data  (core_beat),
    .i_valid (core_valid),
    .o_ready (core_ready),
    .o_data  (out_beat),
    .o_valid (o_rx_tvalid),
    .i_ready (i_rx_tready)
  );

  assign o_rx_tdata = out_beat.data;
  assign o_rx_tlast = out_beat.last;
  assign o_rx_tuser = out_beat.header;

endmodule

// ==== src/rx_ctrl_core.sv ====
module rx_ctrl_core (
  input  logic                     clk,
  input  logic                     i_rst_n,
  input  logic                     i_clear,
  input  rx_radio_pkg::vita_time_t i_vita_time,
  input  rx_radio_pkg::sid_t       i_sid,
  input  rx_radio_pkg::sid_t       i_resp_sid,
  input  rx_radio_pkg::sample_t    i_sample,
  input  logic                     i_strobe,
  input  logic                     i_now,
  input  logic                     i_late,
  rx_cmd_if.core                   cmd_if,
  output rx_radio_pkg::rx_beat_t   o_beat,
  output logic                     o_beat_valid,
  input  logic                     i_beat_ready,
  output logic                     o_run
);
  import rx_radio_pkg::*;
  import rx_ctrl_pkg::*;

  rx_state_t   state;
  logic [27:0] lines_left;
  logic [27:0] repeat_lines;
  maxlen_t     pkt_left;
  logic        pkt_first;
  logic        chain_sav;
  logic        reload_sav;
  seqnum_t     seqnum;
  seqnum_t     seq_next;
  logic        halt_done_q;
  logic        cmd_settled;
  vita_time_t  start_time;
  rx_err_t     err_code;
  rx_header_t  data_hdr;
  rx_header_t  err_hdr;

  logic beat_free;
  logic last_line;
  logic pkt_end;
  logic eob;
  logic idle_take;
  logic run_take;
  logic run_overrun;
  logic chain_pop;
  logic late_cmd;
  logic broken_chain;
  logic err_first;
  logic err_second;

  assign beat_free = !o_beat_valid || i_beat_ready;
  assign last_line = (lines_left == 28'd1);
  assign pkt_end   = (pkt_left == 16'd1);

  // Burst ends on this line unless a chain or reload carries it on
  assign eob = last_line && (!chain_sav || cmd_if.halt ||
                             (cmd_if.cmd_valid && cmd_if.cmd.stop) ||
                             (!cmd_if.cmd_valid && !reload_sav));

  // Time compare lags the queue head by a cycle, so wait for cmd_settled
  assign idle_take = (state == IDLE) && cmd_if.cmd_valid && cmd_settled && beat_free &&
                     !halt_done_q &&
                     (cmd_if.cmd.stop || cmd_if.cmd.send_imm || i_now || i_late);
  assign late_cmd  = idle_take && !cmd_if.cmd.stop && i_late && !cmd_if.cmd.send_imm;

  assign run_overrun  = (state == RUNNING) && !beat_free;   // Held beat refused
  assign run_take     = (state == RUNNING) && beat_free && i_strobe;
  assign chain_pop    = run_take && last_line && !cmd_if.halt && chain_sav && cmd_if.cmd_valid;
  assign broken_chain = run_take && last_line && !cmd_if.halt && chain_sav &&
                        !cmd_if.cmd_valid && !reload_sav;

  assign err_first  = (state == ERR_WAIT) && beat_free;
  assign err_second = (state == ERR_SEND) && beat_free && !o_beat.last;

  assign cmd_if.cmd_ready = idle_take || chain_pop;
  assign cmd_if.halt_done = halt_done_q;
  assign cmd_if.flush     = halt_done_q;    // Pending commands go with the halt

  // A packet ending in this cycle already counts for the next header
  assign seq_next = (o_beat_valid && i_beat_ready && o_beat.last) ? seqnum + 12'd1 : seqnum;

  assign data_hdr = '{is_error: 1'b0, eob: eob, seqnum: seq_next, sid: i_sid,
                      timestamp: pkt_first ? i_vita_time : start_time};
  assign err_hdr  = '{is_error: 1'b1, eob: 1'b1, seqnum: seq_next, sid: i_resp_sid,
                      timestamp: i_vita_time};

  always_ff @(posedge clk) begin
    if (!i_rst_n || i_clear) begin
      state        <= IDLE;
      o_run        <= 1'b0;
      o_beat_valid <= 1'b0;
      lines_left   <= '0;
      repeat_lines <= '0;
      pkt_left     <= '0;
      pkt_first    <= 1'b0;
      chain_sav    <= 1'b0;
      reload_sav   <= 1'b0;
      seqnum       <= '0;
      halt_done_q  <= 1'b0;
      cmd_settled  <= 1'b0;
    end else begin
      halt_done_q <= 1'b0;
      cmd_settled <= cmd_if.cmd_valid && !cmd_if.cmd_ready;
      seqnum      <= seq_next;
      case (state)
        IDLE: begin
          if (beat_free) o_beat_valid <= 1'b0;
          if (late_cmd) begin
            state <= ERR_WAIT;
          end else if (idle_take && !cmd_if.cmd.stop) begin   // Stop commands just drop
            lines_left   <= cmd_if.cmd.numlines;
            repeat_lines <= cmd_if.cmd.numlines;
            chain_sav    <= cmd_if.cmd.chain;
            reload_sav   <= cmd_if.cmd.reload;
            pkt_left     <= cmd_if.maxlen;
            pkt_first    <= 1'b1;
            state        <= RUNNING;
            o_run        <= 1'b1;
          end
        end
        RUNNING: begin
          if (run_overrun) begin
            state <= ERR_WAIT;      // Beat stays valid, marked last
            o_run <= 1'b0;
          end else if (i_strobe) begin
            o_beat_valid <= 1'b1;
            pkt_first    <= pkt_end;
            pkt_left     <= pkt_end ? cmd_if.maxlen : pkt_left - 16'd1;
            if (!last_line) begin
              lines_left <= lines_left - 28'd1;
            end else if (cmd_if.halt) begin
              state       <= IDLE;
              o_run       <= 1'b0;
              halt_done_q <= 1'b1;
            end else if (chain_sav && cmd_if.cmd_valid) begin
              if (cmd_if.cmd.stop) begin
                state <= IDLE;
                o_run <= 1'b0;
              end else begin
                lines_left   <= cmd_if.cmd.numlines;
                repeat_lines <= cmd_if.cmd.numlines;
                chain_sav    <= cmd_if.cmd.chain;
                reload_sav   <= cmd_if.cmd.reload;
              end
            end else if (chain_sav && reload_sav) begin
              lines_left <= repeat_lines;
            end else begin
              state <= chain_sav ? ERR_WAIT : IDLE;   // Broken chain or plain end
              o_run <= 1'b0;
            end
          end else begin
            o_beat_valid <= 1'b0;
          end
        end
        ERR_WAIT: begin
          if (beat_free) begin
            o_beat_valid <= 1'b1;
            state        <= ERR_SEND;
          end
        end
        ERR_SEND: begin
          if (beat_free) begin
            if (o_beat.last) begin
              o_beat_valid <= 1'b0;
              state        <= IDLE;
            end else begin
              o_beat_valid <= 1'b1;
            end
          end
        end
        default: begin
          state <= IDLE;
          o_run <= 1'b0;
        end
      endcase
    end
  end

  // Beat contents, error code and packet start time
  always_ff @(posedge clk) begin
    if (run_overrun) begin
      o_beat.last       <= 1'b1;
      o_beat.header.eob <= 1'b1;
    end else if (run_take) begin
      o_beat <= '{data: i_sample, last: eob || pkt_end, header: data_hdr};
    end else if (err_first) begin
      o_beat <= '{data: err_code, last: 1'b0, header: err_hdr};
    end else if (err_second) begin
      o_beat <= '{data: '0, last: 1'b1, header: err_hdr};
    end

    if (run_take && pkt_first) start_time <= i_vita_time;

    if (run_overrun) begin
      err_code <= ERR_OVERRUN;
    end else if (broken_chain) begin
      err_code <= ERR_BROKENCHAIN;
    end else if (late_cmd) begin
      err_code <= ERR_LATECMD;
    end
  end

  a_state_legal: assert property (@(posedge clk) disable iff (!i_rst_n)
    state inside {IDLE, RUNNING, ERR_WAIT, ERR_SEND});

  // o_run is its own flop and must track every state change
  a_run_state: assert property (@(posedge clk) disable iff (!i_rst_n)
    o_run == (state == RUNNING));

endmodule

// ==== src/rx_time_compare.sv ====
module rx_time_compare (
  input  logic                     clk,
  input  logic                     i_rst_n,
  input  rx_radio_pkg::vita_time_t i_time_now,
  input  rx_radio_pkg::vita_time_t i_trigger_time,
  output logic                     o_now,
  output logic                     o_late
);

  // Full 64-bit compare, registered to keep it off the core's decision path
  always_ff @(posedge clk) begin
    if (!i_rst_n) begin
      o_now  <= 1'b0;
      o_late <= 1'b0;
    end else begin
      o_now  <= (i_time_now == i_trigger_time);
      o_late <= (i_time_now > i_trigger_time);   // Execute time already passed
    end
  end

endmodule

// ==== src/rx_cmd_settings.sv ====
module rx_cmd_settings (
  input  logic                   clk,
  input  logic                   i_rst_n,
  input  logic                   i_clear,
  input  logic                   i_set_stb,
  input  rx_ctrl_pkg::set_addr_t i_set_addr,
  input  logic [31:0]            i_set_data,
  rx_cmd_if.settings             cmd_if
);
  import rx_ctrl_pkg::*;

  logic [31:0] cmd_word;
  logic [31:0] time_hi;
  logic        push_cmd;
  logic        set_halt;
  logic        clear_cmds;
  logic        fifo_clear;
  rx_cmd_t     new_cmd;

  // Address decode, each strobe is a single write
  assign push_cmd   = i_set_stb && (i_set_addr == SR_TIME_LO);
  assign set_halt   = i_set_stb && (i_set_addr == SR_HALT);
  assign clear_cmds = i_set_stb && (i_set_addr == SR_CLEAR_CMDS);

  // Low time word comes straight from the bus so the push happens on its write
  assign new_cmd = {cmd_word, time_hi, i_set_data};

  always_ff @(posedge clk) begin
    if (i_set_stb && (i_set_addr == SR_COMMAND)) cmd_word <= i_set_data;
    if (i_set_stb && (i_set_addr == SR_TIME_HI)) time_hi <= i_set_data;
  end

  always_ff @(posedge clk) begin
    if (!i_rst_n) begin
      cmd_if.maxlen <= MAXLEN_DEFAULT;
    end else if (i_set_stb && (i_set_addr == SR_MAXLEN)) begin
      cmd_if.maxlen <= i_set_data[15:0];
    end
  end

  // Halt stays up until the core has acted on it
  always_ff @(posedge clk) begin
    if (!i_rst_n || i_clear || clear_cmds || cmd_if.halt_done) begin
      cmd_if.halt <= 1'b0;
    end else if (set_halt) begin
      cmd_if.halt <= 1'b1;
    end
  end

  assign fifo_clear = i_clear || clear_cmds || cmd_if.flush;

  rx_short_fifo #(
    .T     (rx_cmd_t),
    .DEPTH (CMD_FIFO_DEPTH)
  ) u_cmd_fifo (
    .clk     (clk),
    .i_rst_n (i_rst_n),
    .i_clear (fifo_clear),
    .i_data  (new_cmd),
    .i_valid (push_cmd),
    .o_ready (),            // Host keeps the queue from overflowing
    .o_data  (cmd_if.cmd),
    .o_valid (cmd_if.cmd_valid),
    .i_ready (cmd_if.cmd_ready)
  );

endmodule

// ==== src/rx_short_fifo.sv ====
module rx_short_fifo #(
  parameter type T     = logic [31:0],
  parameter int  DEPTH = 16
) (
  input  logic clk,
  input  logic i_rst_n,
  input  logic i_clear,
  input  T     i_data,
  input  logic i_valid,
  output logic o_ready,
  output T     o_data,
  output logic o_valid,
  input  logic i_ready
);

  T                             mem [DEPTH];
  logic [$clog2(DEPTH)-1:0]     wr_ptr;
  logic [$clog2(DEPTH)-1:0]     rd_ptr;
  logic [$clog2(DEPTH+1)-1:0]   count;
  logic                         push;
  logic                         pop;

  assign o_valid = (count != '0);
  assign o_ready = (int'(count) < DEPTH);  // Full queue drops pushes
  assign o_data  = mem[rd_ptr];

  assign push = i_valid && o_ready;
  assign pop  = o_valid && i_ready;

  always_ff @(posedge clk) begin
    if (push) mem[wr_ptr] <= i_data;
  end

  always_ff @(posedge clk) begin
    if (!i_rst_n || i_clear) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) wr_ptr <= (int'(wr_ptr) == DEPTH - 1) ? '0 : wr_ptr + 1'b1;
      if (pop)  rd_ptr <= (int'(rd_ptr) == DEPTH - 1) ? '0 : rd_ptr + 1'b1;
      if (push && !pop) begin
        count <= count + 1'b1;
      end else if (pop && !push) begin
        count <= count - 1'b1;
      end
    end
  end

  // A refused write must leave the buffer full with the pointers meeting
  a_no_push_full: assert property (@(posedge clk) disable iff (!i_rst_n || i_clear)
    !o_ready && !pop |=> (int'(count) == DEPTH) && (wr_ptr == rd_ptr));

endmodule

// ==== src/rx_cmd_if.sv ====
interface rx_cmd_if;
  import rx_ctrl_pkg::*;

  rx_cmd_t cmd;        // Head of the command queue
  logic    cmd_valid;
  logic    cmd_ready;  // Pop the head command
  logic    halt;       // Sticky halt request
  maxlen_t maxlen;     // Beats per packet
  logic    halt_done;  // Core reached idle on a halt
  logic    flush;      // Core asks for the queue to be emptied

  modport settings (
    output cmd,
    output cmd_valid,
    output halt,
    output maxlen,
    input  cmd_ready,
    input  halt_done,
    input  flush
  );

  modport core (
    input  cmd,
    input  cmd_valid,
    input  halt,
    input  maxlen,
    output cmd_ready,
    output halt_done,
    output flush
  );

endinterface

// ==== src/rx_ctrl_pkg.sv ====
package rx_ctrl_pkg;

  // Settings bus addresses
  typedef logic [7:0] set_addr_t;

  localparam set_addr_t SR_COMMAND    = 8'd0;
  localparam set_addr_t SR_TIME_HI    = 8'd1;
  localparam set_addr_t SR_TIME_LO    = 8'd2;  // Write here pushes the command
  localparam set_addr_t SR_HALT       = 8'd3;
  localparam set_addr_t SR_MAXLEN     = 8'd4;
  localparam set_addr_t SR_CLEAR_CMDS = 8'd5;

  // Queued command, same bit order as the command word then the time words
  typedef struct packed {
    logic        send_imm;   // Ignore exec_time and start at once
    logic        chain;      // Take the next queued command when done
    logic        reload;     // Repeat this command if nothing follows
    logic        stop;       // End a chain
    logic [27:0] numlines;
    logic [63:0] exec_time;
  } rx_cmd_t;

  typedef logic [15:0] maxlen_t;

  localparam maxlen_t MAXLEN_DEFAULT = 16'd64;

  // Error codes sent in the first beat of an error packet
  typedef logic [31:0] rx_err_t;

  localparam rx_err_t ERR_LATECMD     = 32'd2;
  localparam rx_err_t ERR_BROKENCHAIN = 32'd4;
  localparam rx_err_t ERR_OVERRUN     = 32'd8;

  typedef enum logic [1:0] {
    IDLE,
    RUNNING,
    ERR_WAIT,   // Waiting to put out the error code beat
    ERR_SEND    // Error code beat out, trailing beat follows
  } rx_state_t;

  // Queue depths
  localparam int CMD_FIFO_DEPTH = 16;
  localparam int OUT_FIFO_DEPTH = 2;

endpackage

// ==== src/rx_radio_pkg.sv ====
package rx_radio_pkg;

  // One strobed sample from the radio frontend
  typedef logic [31:0] sample_t;

  // Free running radio time
  typedef logic [63:0] vita_time_t;

  typedef logic [31:0] sid_t;
  typedef logic [11:0] seqnum_t;

  // Header that travels with every output beat
  typedef struct packed {
    logic       is_error;   // Error packet, not sample data
    logic       eob;        // End of burst
    seqnum_t    seqnum;
    sid_t       sid;
    vita_time_t timestamp;  // Time of the first sample in the packet
  } rx_header_t;

  // One beat of the output stream
  typedef struct packed {
    sample_t    data;
    logic       last;       // Last beat of a packet
    rx_header_t header;
  } rx_beat_t;

endpackage
